// File: design/vmem_pkg.sv
package vmem_pkg;

   // memory and host data word
   typedef logic [31:0] data_t;

   // configuration register index, driven by the host on cfg_sel
   typedef logic [2:0] cfg_sel_t;

   localparam cfg_sel_t sel_iterations = 3'd0;
   localparam cfg_sel_t sel_period     = 3'd1;
   localparam cfg_sel_t sel_duty       = 3'd2;
   localparam cfg_sel_t sel_delay      = 3'd3;
   localparam cfg_sel_t sel_start      = 3'd4;
   localparam cfg_sel_t sel_shift      = 3'd5;
   localparam cfg_sel_t sel_incr       = 3'd6;
   // index 7 is a hole, writes fall through

   // address generator state
   typedef enum logic {
      idle    = 1'b0,
      running = 1'b1
   } agen_state_e;

endpackage

// File: design/agen_cfg_if.sv
interface agen_cfg_if #(
   parameter int DADDR_W  = 10,
   parameter int PERIOD_W = 5
);

   logic        [DADDR_W-1:0]  iterations;  // number of periods
   logic        [PERIOD_W-1:0] period;
   logic        [PERIOD_W-1:0] duty;        // enabled cycles per period
   logic        [PERIOD_W-1:0] delay;       // cycles before the first period
   logic        [DADDR_W-1:0]  start;
   logic signed [DADDR_W-1:0]  shift;       // extra step at each period boundary
   logic signed [DADDR_W-1:0]  incr;

   // register side
   modport cfg (
      output iterations, period, duty, delay, start, shift, incr
   );

   // generator side
   modport agen (
      input iterations, period, duty, delay, start, shift, incr
   );

endinterface

// File: design/cfg_decode.sv
module cfg_decode import vmem_pkg::*; #(
   parameter int DADDR_W  = 10,
   parameter int PERIOD_W = 5
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     cfg_we,
   input  cfg_sel_t cfg_sel,
   input  data_t    cfg_wdata,
   input  logic     done,
   agen_cfg_if.cfg  cfg
);

   logic        [DADDR_W-1:0]  iterations_q;
   logic        [PERIOD_W-1:0] period_q;
   logic        [PERIOD_W-1:0] duty_q;
   logic        [PERIOD_W-1:0] delay_q;
   logic        [DADDR_W-1:0]  start_q;
   logic signed [DADDR_W-1:0]  shift_q;
   logic signed [DADDR_W-1:0]  incr_q;

   logic wr_ok;

   // registers only change between runs
   assign wr_ok = cfg_we & done;

   always_ff @(posedge clk) begin
      if (rst) begin
         iterations_q <= '0;
         period_q     <= '0;
         duty_q       <= '0;
         delay_q      <= '0;
         start_q      <= '0;
         shift_q      <= '0;
         incr_q       <= '0;
      end else if (wr_ok) begin
         case (cfg_sel)
            sel_iterations: iterations_q <= cfg_wdata[DADDR_W-1:0];
            sel_period:     period_q     <= cfg_wdata[PERIOD_W-1:0];
            sel_duty:       duty_q       <= cfg_wdata[PERIOD_W-1:0];
            sel_delay:      delay_q      <= cfg_wdata[PERIOD_W-1:0];
            sel_start:      start_q      <= cfg_wdata[DADDR_W-1:0];
            // low bits of a sign-extended host word keep the sign
            sel_shift:      shift_q      <= signed'(cfg_wdata[DADDR_W-1:0]);
            sel_incr:       incr_q       <= signed'(cfg_wdata[DADDR_W-1:0]);
            default: ;      // unused index
         endcase
      end
   end

   assign cfg.iterations = iterations_q;
   assign cfg.period     = period_q;
   assign cfg.duty       = duty_q;
   assign cfg.delay      = delay_q;
   assign cfg.start      = start_q;
   assign cfg.shift      = shift_q;
   assign cfg.incr       = incr_q;

endmodule

// File: design/addr_gen.sv
module addr_gen import vmem_pkg::*; #(
   parameter int DADDR_W  = 10,
   parameter int PERIOD_W = 5
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               init,
   input  logic               run,
   agen_cfg_if.agen           cfg,
   output logic [DADDR_W-1:0] addr,
   output logic               mem_en,
   output logic               done
);

   typedef logic [DADDR_W-1:0]       addr_t;
   typedef logic signed [PERIOD_W:0] pcnt_t;  // extra bit, counts up from minus delay

   agen_state_e state;
   agen_state_e state_nxt;

   pcnt_t per_cnt;
   pcnt_t per_cnt_nxt;
   pcnt_t period_int;
   pcnt_t duty_int;

   addr_t addr_nxt;
   addr_t iter;
   addr_t iter_nxt;

   logic mem_en_nxt;
   logic done_nxt;
   logic per_end;
   logic duty_end;
   logic last_iter;
   logic gapped;

   assign period_int = pcnt_t'({1'b0, cfg.period});
   assign duty_int   = pcnt_t'({1'b0, cfg.duty});

   assign per_end   = (per_cnt == period_int);
   assign duty_end  = (per_cnt == duty_int);
   assign last_iter = (iter == cfg.iterations);
   assign gapped    = (cfg.period != cfg.duty);  // idle cycles inside each period

   always_comb begin
      state_nxt   = state;
      done_nxt    = done;
      mem_en_nxt  = mem_en;
      per_cnt_nxt = per_cnt;
      addr_nxt    = addr;
      iter_nxt    = iter;

      if (state == idle) begin
         if (init) begin
            per_cnt_nxt = pcnt_t'(1) - pcnt_t'({1'b0, cfg.delay});
            addr_nxt    = cfg.start;
            iter_nxt    = addr_t'(1);
         end
         if (run) begin
            state_nxt = running;
            done_nxt  = 1'b0;
            if (cfg.delay == '0)
               mem_en_nxt = 1'b1;  // no delay, first read right away
         end
      end else begin
         // enable window
         if (per_cnt == '0 || (per_end && !last_iter))
            mem_en_nxt = 1'b1;
         if (duty_end && (gapped || last_iter))
            mem_en_nxt = 1'b0;

         // period and iteration counters
         if (per_end) begin
            per_cnt_nxt = pcnt_t'(1);
            iter_nxt    = iter + addr_t'(1);
         end else begin
            per_cnt_nxt = per_cnt + pcnt_t'(1);
         end

         // address walk
         if (mem_en)
            addr_nxt = addr + cfg.incr;
         if (per_end)
            addr_nxt = addr + cfg.incr + cfg.shift;
         if (mem_en && duty_end && gapped)
            addr_nxt = addr;  // hold through the gap

         if (last_iter && per_end) begin
            state_nxt = idle;
            done_nxt  = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= idle;
         mem_en  <= 1'b0;
         done    <= 1'b1;
         addr    <= '0;
         per_cnt <= '0;
         iter    <= '0;
      end else begin
         state   <= state_nxt;
         mem_en  <= mem_en_nxt;
         done    <= done_nxt;
         addr    <= addr_nxt;
         per_cnt <= per_cnt_nxt;
         iter    <= iter_nxt;
      end
   end

endmodule

// File: design/mem_bank.sv
module mem_bank import vmem_pkg::*; #(
   parameter int DADDR_W = 10
) (
   input  logic               clk,
   input  logic               we,
   input  logic [DADDR_W-1:0] waddr,
   input  data_t              wdata,
   input  logic [DADDR_W-1:0] raddr,
   input  logic               ren,
   output data_t              rd_data,
   output logic               rd_valid,
   input  logic               rst
);

   localparam int DEPTH = 2 ** DADDR_W;

   data_t mem [DEPTH];

   // host port, no arbitration with the read side
   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // read port driven by the generator
   always_ff @(posedge clk) begin
      if (ren)
         rd_data <= mem[raddr];
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_valid <= 1'b0;
      else
         rd_valid <= ren;  // one cycle read latency
   end

endmodule

// File: design/vmem_unit.sv
module vmem_unit import vmem_pkg::*; #(
   parameter int DADDR_W  = 10,
   parameter int PERIOD_W = 5
) (
   input  logic               clk,
   input  logic               rst,

   // host memory write
   input  logic               mem_we,
   input  logic [DADDR_W-1:0] mem_waddr,
   input  data_t              mem_wdata,

   // configuration write
   input  logic               cfg_we,
   input  cfg_sel_t           cfg_sel,
   input  data_t              cfg_wdata,

   input  logic               init,
   input  logic               run,

   output data_t              rd_data,
   output logic               rd_valid,
   output logic               done
);

   logic [DADDR_W-1:0] addr;
   logic               mem_en;

   agen_cfg_if #(.DADDR_W(DADDR_W), .PERIOD_W(PERIOD_W)) cfg_bus ();

   cfg_decode #(.DADDR_W(DADDR_W), .PERIOD_W(PERIOD_W)) u_decode (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_sel   (cfg_sel),
      .cfg_wdata (cfg_wdata),
      .done      (done),      // locks the registers during a run
      .cfg       (cfg_bus.cfg)
   );

   addr_gen #(.DADDR_W(DADDR_W), .PERIOD_W(PERIOD_W)) u_agen (
      .clk    (clk),
      .rst    (rst),
      .init   (init),
      .run    (run),
      .cfg    (cfg_bus.agen),
      .addr   (addr),
      .mem_en (mem_en),
      .done   (done)
   );

   mem_bank #(.DADDR_W(DADDR_W)) u_mem (
      .clk      (clk),
      .we       (mem_we),
      .waddr    (mem_waddr),
      .wdata    (mem_wdata),
      .raddr    (addr),
      .ren      (mem_en),
      .rd_data  (rd_data),
      .rd_valid (rd_valid),
      .rst      (rst)
   );

endmodule

// File: dv/vmem_unit_props.sv
module vmem_unit_props
   import vmem_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        run,
   input logic        mem_en,
   input logic        done,
   input agen_state_e state
);
   timeunit 1ns;
   timeprecision 100ps;

   // reads only inside a run
   en_inside_run: assert property (
      @(posedge clk) disable iff (rst) !(mem_en && done)
   ) else $error("mem_en high while done is high");

   run_drops_done: assert property (
      @(posedge clk) disable iff (rst) (state == idle && run) |=> !done
   ) else $error("done still high the cycle after run while idle");

   // end of run only out of running
   done_from_running: assert property (
      @(posedge clk) disable iff (rst) $rose(done) |-> $past(state) == running
   ) else $error("done rose while the generator was not running");

endmodule

bind addr_gen vmem_unit_props u_props (
   .clk    (clk),
   .rst    (rst),
   .run    (run),
   .mem_en (mem_en),
   .done   (done),
   .state  (state)
);

// File: dv/vmem_unit_tb.sv
module vmem_unit_tb
   import vmem_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DADDR_W  = 10;
   localparam int PERIOD_W = 5;
   localparam int DEPTH    = 1 << DADDR_W;
   localparam int NUM_RAND = 20;
   localparam int NUM_CFG  = 3 + NUM_RAND;  // contiguous, gapped, lock, then random

   typedef struct packed {
      int iterations;
      int period;
      int duty;
      int delay;
      int start;
      int shift;
      int incr;
   } run_cfg_t;

   logic               clk;
   logic               rst;
   logic               mem_we;
   logic [DADDR_W-1:0] mem_waddr;
   data_t              mem_wdata;
   logic               cfg_we;
   cfg_sel_t           cfg_sel;
   data_t              cfg_wdata;
   logic               init;
   logic               run;
   data_t              rd_data;
   logic               rd_valid;
   logic               done;

   run_cfg_t runs [NUM_CFG];
   data_t    exp_q [$];
   int       cycle_cnt;
   int       cycle_limit;
   logic     waiting;  // high while a run is in flight

   vmem_unit #(.DADDR_W(DADDR_W), .PERIOD_W(PERIOD_W)) uut (
      .clk       (clk),
      .rst       (rst),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata),
      .cfg_we    (cfg_we),
      .cfg_sel   (cfg_sel),
      .cfg_wdata (cfg_wdata),
      .init      (init),
      .run       (run),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // preload word for address a with a per-test salt
   function automatic data_t scramble(int a, int salt);
      return (data_t'(a) * 32'h9e3779b1) ^ (data_t'(salt) << 20) ^ data_t'(a);
   endfunction

   // expected stream from the two-level address rule
   function automatic void build_expected(run_cfg_t c, int salt);
      int a;
      for (int j = 0; j < c.iterations; j++) begin
         for (int k = 0; k < c.duty; k++) begin
            a = (c.start + j * (c.duty * c.incr + c.shift) + k * c.incr) & (DEPTH - 1);
            exp_q.push_back(scramble(a, salt));
         end
      end
   endfunction

   function automatic int run_cycles(run_cfg_t c);
      return c.delay + c.period * c.iterations + 4;
   endfunction

   function automatic run_cfg_t random_cfg();
      run_cfg_t c;
      c.period     = int'($urandom_range(12, 1));
      c.duty       = int'($urandom_range(c.period, 1));
      c.delay      = int'($urandom_range(9, 0));
      c.iterations = int'($urandom_range(6, 1));
      c.start      = int'($urandom_range(DEPTH - 1, 0));
      c.shift      = int'($urandom_range(40, 0)) - 20;
      c.incr       = int'($urandom_range(10, 0)) - 5;
      return c;
   endfunction

   task automatic step_clock();
      @(posedge clk);
      #1;
   endtask

   task automatic expect_bit(string name, logic got, logic want);
      assert (got === want) else begin
         $display("FAIL %s = 0x%0h, expected 0x%0h", name, got, want);
         $display("Test failed");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic preload_memory(int salt);
      for (int a = 0; a < DEPTH; a++) begin
         mem_we    = 1'b1;
         mem_waddr = DADDR_W'(a);
         mem_wdata = scramble(a, salt);
         step_clock();
      end
      mem_we = 1'b0;
   endtask

   task automatic write_cfg(cfg_sel_t sel, data_t value);
      cfg_we    = 1'b1;
      cfg_sel   = sel;
      cfg_wdata = value;
      step_clock();
      cfg_we    = 1'b0;
   endtask

   task automatic load_config(run_cfg_t c);
      write_cfg(sel_iterations, data_t'(c.iterations));
      write_cfg(sel_period, data_t'(c.period));
      write_cfg(sel_duty, data_t'(c.duty));
      write_cfg(sel_delay, data_t'(c.delay));
      write_cfg(sel_start, data_t'(c.start));
      write_cfg(sel_shift, data_t'(c.shift));  // sign extended
      write_cfg(sel_incr, data_t'(c.incr));
   endtask

   task automatic start_run();
      init = 1'b1;
      step_clock();
      init = 1'b0;
      run  = 1'b1;
      step_clock();
      run     = 1'b0;
      waiting = 1'b1;
   endtask

   task automatic wait_done();
      while (!done)
         step_clock();
      waiting = 1'b0;
      step_clock();  // last word lands with done
   endtask

   task automatic check_run_end();
      assert (exp_q.size() == 0) else begin
         $display("run ended with %0d expected words missing from the stream", exp_q.size());
         $display("Test failed");
         $fatal(1, "missing words");
      end
   endtask

   task automatic execute_run(run_cfg_t c, int salt);
      build_expected(c, salt);
      start_run();
      wait_done();
      check_run_end();
   endtask

   // compare at the falling edge where outputs are settled
   always @(negedge clk) begin
      data_t exp_word;
      if (!rst && rd_valid) begin
         assert (exp_q.size() > 0) else begin
            $display("unexpected word 0x%08h on the stream with none expected", rd_data);
            $display("Test failed");
            $fatal(1, "extra word");
         end
         exp_word = exp_q.pop_front();
         assert (rd_data === exp_word) else begin
            $display("FAIL rd_data = 0x%08h, expected 0x%08h", rd_data, exp_word);
            $display("Test failed");
            $fatal(1, "rd_data mismatch");
         end
      end
   end

   always @(posedge clk) begin
      if (waiting) begin
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt > cycle_limit) begin
            $display("timeout, done did not rise within %0d run cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      void'($urandom(32'h9a62));
      rst       = 1'b1;
      mem_we    = 1'b0;
      mem_waddr = '0;
      mem_wdata = '0;
      cfg_we    = 1'b0;
      cfg_sel   = '0;
      cfg_wdata = '0;
      init      = 1'b0;
      run       = 1'b0;
      waiting   = 1'b0;
      cycle_cnt = 0;

      runs[0] = '{iterations: 6, period: 4, duty: 4, delay: 0, start: 100, shift: 0, incr: 1};
      runs[1] = '{iterations: 5, period: 7, duty: 3, delay: 5, start: 40, shift: -4, incr: 2};
      runs[2] = '{iterations: 6, period: 5, duty: 3, delay: 2, start: 1010, shift: 1, incr: 3};
      for (int i = 3; i < NUM_CFG; i++)
         runs[i] = random_cfg();

      cycle_limit = run_cycles(runs[2]);  // lock test runs twice
      for (int i = 0; i < NUM_CFG; i++)
         cycle_limit = cycle_limit + run_cycles(runs[i]);
      cycle_limit = 2 * cycle_limit;

      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      // idle after reset and nothing streams
      expect_bit("done", done, 1'b1);
      expect_bit("rd_valid", rd_valid, 1'b0);
      repeat (20) step_clock();
      expect_bit("done", done, 1'b1);

      // contiguous run and then gaps with a negative shift
      for (int i = 0; i < 2; i++) begin
         load_config(runs[i]);
         preload_memory(i);
         execute_run(runs[i], i);
      end

      // writes during a run are dropped
      load_config(runs[2]);
      preload_memory(2);
      build_expected(runs[2], 2);
      start_run();
      expect_bit("done", done, 1'b0);
      write_cfg(sel_incr, 32'd7);
      write_cfg(sel_iterations, 32'd1);
      wait_done();
      check_run_end();
      execute_run(runs[2], 2);  // rerun sees the old fields

      for (int i = 3; i < NUM_CFG; i++) begin
         load_config(runs[i]);
         preload_memory(i);
         execute_run(runs[i], i);
      end

      $display("Test passed");
      $finish;
   end

endmodule

// File: vmem_unit.f
design/vmem_pkg.sv
design/agen_cfg_if.sv
design/cfg_decode.sv
design/addr_gen.sv
design/mem_bank.sv
design/vmem_unit.sv
dv/vmem_unit_props.sv
dv/vmem_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vmem_unit_tb
FILELIST  ?= vmem_unit.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: sim clean

# the binary exits nonzero on $fatal or a failed assertion
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
